// File: sources.f
hdl/rv64_pkg.sv
hdl/int_pkg.sv
hdl/int_alu.sv
hdl/int_target_gen.sv
hdl/int_commit.sv
hdl/int_pipe.sv
sim/int_pipe_assertions.sv
sim/int_pipe_tb.sv

// File: Bender.yml
package:
  name: int_pipe

sources:
  - files:
      - hdl/rv64_pkg.sv
      - hdl/int_pkg.sv
      - hdl/int_alu.sv
      - hdl/int_target_gen.sv
      - hdl/int_commit.sv
      - hdl/int_pipe.sv
  - target: simulation
    files:
      - sim/int_pipe_assertions.sv
      - sim/int_pipe_tb.sv

// File: sim/int_pipe_tb.sv
// Runs only at vaddr_width_p 39 and models the data outputs as holding while their enables are low
module int_pipe_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int vaddr_width_lp  = 39;
   localparam int clk_period_lp   = 8;
   localparam int reset_cycles_lp = 10;
   localparam int max_cases_lp    = 128;

   logic                      clk_i;
   logic                      reset_i;
   logic                      valid_i;
   logic [vaddr_width_lp-1:0] pc_i;
   logic [63:0]               src1_i;
   logic [63:0]               src2_i;
   logic [63:0]               imm_i;
   int_pkg::int_fu_op_e       fu_op_i;
   logic                      opw_v_i;
   int_pkg::int_class_e       class_i;
   logic                      rd_w_v_o;
   logic [63:0]               rd_data_o;
   logic                      redirect_v_o;
   logic [vaddr_width_lp-1:0] redirect_pc_o;

   // Case table, stimulus then expected outputs
   string                     tc_name        [max_cases_lp];
   logic                      tc_valid       [max_cases_lp];
   int_pkg::int_class_e       tc_class       [max_cases_lp];
   int_pkg::int_fu_op_e       tc_op          [max_cases_lp];
   logic                      tc_opw         [max_cases_lp];
   logic [vaddr_width_lp-1:0] tc_pc          [max_cases_lp];
   logic [63:0]               tc_src1        [max_cases_lp];
   logic [63:0]               tc_src2        [max_cases_lp];
   logic [63:0]               tc_imm         [max_cases_lp];
   logic                      tc_rd_w_v      [max_cases_lp];
   logic [63:0]               tc_rd_data     [max_cases_lp];
   logic                      tc_redirect_v  [max_cases_lp];
   logic [vaddr_width_lp-1:0] tc_redirect_pc [max_cases_lp];

   // Output registers of the model, zero after reset
   logic [63:0]               model_rd_data;
   logic [vaddr_width_lp-1:0] model_redirect_pc;

   integer seed;
   int     n_cases;
   int     errors;
   int     pass_count;
   int     fail_count;
   bit     table_ready;

   int_pipe #(.vaddr_width_p(vaddr_width_lp)) dut_i
   (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .valid_i       (valid_i),
      .pc_i          (pc_i),
      .src1_i        (src1_i),
      .src2_i        (src2_i),
      .imm_i         (imm_i),
      .fu_op_i       (fu_op_i),
      .opw_v_i       (opw_v_i),
      .class_i       (class_i),
      .rd_w_v_o      (rd_w_v_o),
      .rd_data_o     (rd_data_o),
      .redirect_v_o  (redirect_v_o),
      .redirect_pc_o (redirect_pc_o)
   );

   bind int_commit int_pipe_assertions #(.vaddr_width_p(vaddr_width_p)) assertions_i
   (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .valid_i       (valid_i),
      .class_i       (class_i),
      .rd_w_v_o      (rd_w_v_o),
      .redirect_v_o  (redirect_v_o),
      .redirect_pc_o (redirect_pc_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #(clk_period_lp / 2) clk_i = ~clk_i;
   end

   // Reference ALU from the ISA rules
   function automatic logic [63:0] ref_alu(input int_pkg::int_fu_op_e op, input logic opw,
                                           input logic [63:0] a, input logic [63:0] b);
      logic [31:0] w;
      if (opw)
      begin
         case (op)
            int_pkg::e_int_op_add : w = a[31:0] + b[31:0];
            int_pkg::e_int_op_sub : w = a[31:0] - b[31:0];
            int_pkg::e_int_op_sll : w = a[31:0] << b[4:0];
            int_pkg::e_int_op_srl : w = a[31:0] >> b[4:0];
            int_pkg::e_int_op_sra : w = $signed(a[31:0]) >>> b[4:0];
            default               : w = '0;
         endcase
         return {{32{w[31]}}, w};
      end
      case (op)
         int_pkg::e_int_op_add       : return a + b;
         int_pkg::e_int_op_sub       : return a - b;
         int_pkg::e_int_op_xor       : return a ^ b;
         int_pkg::e_int_op_or        : return a | b;
         int_pkg::e_int_op_and       : return a & b;
         int_pkg::e_int_op_sll       : return a << b[5:0];
         int_pkg::e_int_op_srl       : return a >> b[5:0];
         int_pkg::e_int_op_sra       : return $signed(a) >>> b[5:0];
         int_pkg::e_int_op_pass_src2 : return b;
         int_pkg::e_int_op_slt       : return {63'd0, $signed(a) < $signed(b)};
         int_pkg::e_int_op_sge       : return {63'd0, !($signed(a) < $signed(b))};
         int_pkg::e_int_op_eq        : return {63'd0, a == b};
         int_pkg::e_int_op_ne        : return {63'd0, a != b};
         int_pkg::e_int_op_sltu      : return {63'd0, a < b};
         int_pkg::e_int_op_sgeu      : return {63'd0, !(a < b)};
         default                     : return '0;
      endcase
   endfunction

   function automatic logic [63:0] rand64();
      return {$random(seed), $random(seed)};
   endfunction

   // Append one case, expected values follow the commit rules
   task automatic add_case(input string name, input logic valid, input int_pkg::int_class_e cls,
                           input int_pkg::int_fu_op_e op, input logic opw,
                           input logic [vaddr_width_lp-1:0] pc, input logic [63:0] src1,
                           input logic [63:0] src2, input logic [63:0] imm);
      logic [63:0]               alu_res;
      logic [63:0]               jalr_sum;
      logic                      wr;
      logic                      redir;
      logic [vaddr_width_lp-1:0] target;
      alu_res  = ref_alu(op, opw, src1, src2);
      jalr_sum = src1 + imm;
      wr       = valid && (cls != int_pkg::e_class_branch);
      redir    = valid && ((cls == int_pkg::e_class_jal) || (cls == int_pkg::e_class_jalr)
                 || ((cls == int_pkg::e_class_branch) && alu_res[0]));
      if (cls == int_pkg::e_class_jalr)
         target = {jalr_sum[vaddr_width_lp-1:1], 1'b0};
      else
         target = pc + imm[vaddr_width_lp-1:0];
      // Link is pc plus 4, zero extended
      if (wr)
         model_rd_data = (cls == int_pkg::e_class_alu) ? alu_res : 64'(pc + vaddr_width_lp'(4));
      if (redir)
         model_redirect_pc = target;
      tc_name[n_cases]        = name;
      tc_valid[n_cases]       = valid;
      tc_class[n_cases]       = cls;
      tc_op[n_cases]          = op;
      tc_opw[n_cases]         = opw;
      tc_pc[n_cases]          = pc;
      tc_src1[n_cases]        = src1;
      tc_src2[n_cases]        = src2;
      tc_imm[n_cases]         = imm;
      tc_rd_w_v[n_cases]      = wr;
      tc_rd_data[n_cases]     = model_rd_data;
      tc_redirect_v[n_cases]  = redir;
      tc_redirect_pc[n_cases] = model_redirect_pc;
      n_cases++;
   endtask

   task automatic alu_case(input string name, input int_pkg::int_fu_op_e op, input logic opw,
                           input logic [63:0] a, input logic [63:0] b);
      add_case(name, 1'b1, int_pkg::e_class_alu, op, opw, '0, a, b, '0);
   endtask

   task automatic build_table();
      int_pkg::int_fu_op_e op;
      model_rd_data     = '0;
      model_redirect_pc = '0;
      n_cases           = 0;
      // Idle right after reset, nothing written yet
      add_case("idle_after_reset", 1'b0, int_pkg::e_class_alu, int_pkg::e_int_op_add, 1'b0,
               '0, '0, '0, '0);
      // All 15 ops, shift by 63, signed vs unsigned order, equality, random
      for (int k = 0; k < 15; k++)
      begin
         op = int_pkg::int_fu_op_e'(k);
         alu_case({op.name(), "_min_m1"}, op, 1'b0, 64'h8000_0000_0000_0001, '1);
         alu_case({op.name(), "_m1_p1"}, op, 1'b0, '1, 64'd1);
         alu_case({op.name(), "_equal"}, op, 1'b0, 64'd63, 64'd63);
         alu_case({op.name(), "_rand"}, op, 1'b0, rand64(), rand64());
      end
      // Word ops, overflow and negative words
      alu_case("addw_ovf", int_pkg::e_int_op_add, 1'b1, 64'h7FFF_FFFF, 64'd1);
      alu_case("addw_hi", int_pkg::e_int_op_add, 1'b1, 64'hABCD_0000_0000_0005,
               64'h1234_0000_FFFF_FFF0);
      alu_case("subw_neg", int_pkg::e_int_op_sub, 1'b1, 64'd0, 64'd1);
      alu_case("sllw_31", int_pkg::e_int_op_sll, 1'b1, 64'd1, 64'h3F);
      alu_case("srlw_0", int_pkg::e_int_op_srl, 1'b1, 64'hFFFF_FFFF_8000_0000, 64'd0);
      alu_case("srlw_4", int_pkg::e_int_op_srl, 1'b1, 64'h8000_0000, 64'd4);
      alu_case("sraw_4", int_pkg::e_int_op_sra, 1'b1, 64'h8000_0000, 64'd4);
      // Each compare, backward and forward offsets
      // Signed and unsigned order disagree in the lt and gt cases
      for (int k = 9; k < 15; k++)
      begin
         op = int_pkg::int_fu_op_e'(k);
         add_case({"br_", op.name(), "_lt"}, 1'b1, int_pkg::e_class_branch, op, 1'b0,
                  39'h40_0000_1000, -64'sd2, 64'd5, -64'sd16);
         add_case({"br_", op.name(), "_eq"}, 1'b1, int_pkg::e_class_branch, op, 1'b0,
                  39'h00_0000_2000, 64'd5, 64'd5, 64'h40);
         add_case({"br_", op.name(), "_gt"}, 1'b1, int_pkg::e_class_branch, op, 1'b0,
                  39'h00_0000_3000, 64'd5, -64'sd2, -64'sd4);
      end
      add_case("jal_back", 1'b1, int_pkg::e_class_jal, int_pkg::e_int_op_add, 1'b0,
               39'h10_0000_0000, '0, '0, -64'sd2048);
      add_case("jalr_odd", 1'b1, int_pkg::e_class_jalr, int_pkg::e_int_op_add, 1'b0,
               39'h00_0000_4000, 64'h1235, '0, 64'h10);
      // Bubble between jumps, both enables drop
      add_case("bubble", 1'b0, int_pkg::e_class_jal, int_pkg::e_int_op_add, 1'b0,
               '0, 64'd1, 64'd1, '0);
      add_case("jalr_trunc", 1'b1, int_pkg::e_class_jalr, int_pkg::e_int_op_add, 1'b0,
               39'h00_0000_8000, 64'hFFFF_FF80_0000_0003, '0, -64'sd1);
      add_case("jal_fwd", 1'b1, int_pkg::e_class_jal, int_pkg::e_int_op_add, 1'b0,
               39'h00_0000_0FFC, '0, '0, 64'h7FE);
      table_ready = 1'b1;
   endtask

   task automatic apply_case(input int i);
      valid_i <= tc_valid[i];
      class_i <= tc_class[i];
      fu_op_i <= tc_op[i];
      opw_v_i <= tc_opw[i];
      pc_i    <= tc_pc[i];
      src1_i  <= tc_src1[i];
      src2_i  <= tc_src2[i];
      imm_i   <= tc_imm[i];
   endtask

   task automatic check_data(input string name, input string what,
                             input logic [63:0] exp, input logic [63:0] act);
      if (act !== exp)
      begin
         $display("mismatch %s %s: expected %h, actual %h", name, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_pc(input string name, input string what,
                           input logic [vaddr_width_lp-1:0] exp,
                           input logic [vaddr_width_lp-1:0] act);
      if (act !== exp)
      begin
         $display("mismatch %s %s: expected %h, actual %h", name, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input string what, input logic exp,
                             input logic act);
      if (act !== exp)
      begin
         $display("mismatch %s %s: expected %b, actual %b", name, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_case(input int i);
      int errs_before;
      errs_before = errors;
      check_flag(tc_name[i], "rd_w_v", tc_rd_w_v[i], rd_w_v_o);
      check_data(tc_name[i], "rd_data", tc_rd_data[i], rd_data_o);
      check_flag(tc_name[i], "redirect_v", tc_redirect_v[i], redirect_v_o);
      check_pc(tc_name[i], "redirect_pc", tc_redirect_pc[i], redirect_pc_o);
      if (errors == errs_before)
      begin
         pass_count++;
         $display("test %s: ok", tc_name[i]);
      end
      else
      begin
         fail_count++;
         $display("test %s: failed", tc_name[i]);
      end
   endtask

   initial
   begin
      seed       = 74;
      errors     = 0;
      pass_count = 0;
      fail_count = 0;
      build_table();
      reset_i   <= 1'b1;
      apply_case(0);
      // A valid jump during reset must not raise either enable
      valid_i   <= 1'b1;
      class_i   <= int_pkg::e_class_jal;
      repeat (reset_cycles_lp) @(posedge clk_i);
      reset_i <= 1'b0;
      valid_i <= 1'b0;
      // Back to back, each case checked one cycle after it is driven
      for (int i = 0; i <= n_cases; i++)
      begin
         @(posedge clk_i);
         if (i < n_cases)
            apply_case(i);
         else
            valid_i <= 1'b0;
         if (i > 0)
         begin
            @(negedge clk_i);
            check_case(i - 1);
         end
      end
      $display("summary: %0d tests passed, %0d failed, %0d assertion failures", pass_count,
               fail_count, dut_i.commit_i.assertions_i.assert_fail_count);
      if (fail_count == 0 && dut_i.commit_i.assertions_i.assert_fail_count == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

   // Budget of reset, one cycle per case and a margin
   initial
   begin
      wait (table_ready);
      #((reset_cycles_lp + n_cases + 20) * clk_period_lp);
      $display("timeout: the case table did not finish in the expected number of cycles");
      $display("TB FAILED");
      $finish;
   end

endmodule : int_pipe_tb

// File: sim/int_pipe_assertions.sv
// Checks commit-stage outputs only, assumes one cycle latency, bound to int_commit from the testbench
module int_pipe_assertions
#(
   parameter int vaddr_width_p = 39
)
(
   input logic                     clk_i,
   input logic                     reset_i,
   input logic                     valid_i,
   input int_pkg::int_class_e      class_i,
   input logic                     rd_w_v_o,
   input logic                     redirect_v_o,
   input logic [vaddr_width_p-1:0] redirect_pc_o
);
   timeunit 1ns;
   timeprecision 1ps;

   // Tally read by the testbench at the end of the run
   int assert_fail_count = 0;

   // Both enables clear right after reset
   assert property (@(posedge clk_i) reset_i |=> !rd_w_v_o && !redirect_v_o)
      else
      begin
         $error("rd write or redirect enable high in the cycle after reset");
         assert_fail_count = assert_fail_count + 1;
      end

   // Branches never write rd
   assert property (@(posedge clk_i)
      !reset_i && valid_i && (class_i == int_pkg::e_class_branch) |=> !rd_w_v_o)
      else
      begin
         $error("branch produced an rd write");
         assert_fail_count = assert_fail_count + 1;
      end

   // Jumps always redirect
   assert property (@(posedge clk_i)
      !reset_i && valid_i && (class_i inside {int_pkg::e_class_jal, int_pkg::e_class_jalr})
      |=> redirect_v_o)
      else
      begin
         $error("jal or jalr did not redirect");
         assert_fail_count = assert_fail_count + 1;
      end

   // jalr target is halfword aligned
   assert property (@(posedge clk_i)
      !reset_i && valid_i && (class_i == int_pkg::e_class_jalr) |=> !redirect_pc_o[0])
      else
      begin
         $error("jalr redirect target has bit 0 set");
         assert_fail_count = assert_fail_count + 1;
      end

endmodule : int_pipe_assertions

// File: hdl/int_pipe.sv
// Integer execute stage top taking one op per cycle with no back-pressure and results one cycle after valid_i
module int_pipe
#(
   parameter int vaddr_width_p = 39
)
(
   input  logic                     clk_i,
   input  logic                     reset_i,

   // Operation from the operand source
   input  logic                     valid_i,
   input  logic [vaddr_width_p-1:0] pc_i,
   input  logic [63:0]              src1_i,
   input  logic [63:0]              src2_i,
   input  logic [63:0]              imm_i,
   input  int_pkg::int_fu_op_e      fu_op_i,
   input  logic                     opw_v_i,
   input  int_pkg::int_class_e      class_i,

   output logic                     rd_w_v_o,
   output logic [63:0]              rd_data_o,
   output logic                     redirect_v_o,
   output logic [vaddr_width_p-1:0] redirect_pc_o
);

   logic [63:0]              alu_result;
   logic [vaddr_width_p-1:0] target_pc;
   logic [63:0]              link_addr;

   // Arithmetic and branch compare
   int_alu alu_i
   (
      .src1_i   (src1_i),
      .src2_i   (src2_i),
      .op_i     (fu_op_i),
      .opw_v_i  (opw_v_i),
      .result_o (alu_result)
   );

   // Target and link address in parallel with the ALU
   int_target_gen #(.vaddr_width_p(vaddr_width_p)) target_gen_i
   (
      .pc_i        (pc_i),
      .src1_i      (src1_i),
      .imm_i       (imm_i),
      .class_i     (class_i),
      .target_pc_o (target_pc),
      .link_addr_o (link_addr)
   );

   int_commit #(.vaddr_width_p(vaddr_width_p)) commit_i
   (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .valid_i       (valid_i),
      .class_i       (class_i),
      .alu_result_i  (alu_result),
      .link_addr_i   (link_addr),
      .target_pc_i   (target_pc),
      .rd_w_v_o      (rd_w_v_o),
      .rd_data_o     (rd_data_o),
      .redirect_v_o  (redirect_v_o),
      .redirect_pc_o (redirect_pc_o)
   );

endmodule : int_pipe

// File: hdl/int_commit.sv
// Registered commit stage with one cycle latency and no stall, where data outputs hold until their enable fires
module int_commit
#(
   parameter int vaddr_width_p = 39
)
(
   input  logic                     clk_i,
   input  logic                     reset_i,

   input  logic                     valid_i,
   input  int_pkg::int_class_e      class_i,
   input  logic [63:0]              alu_result_i,
   input  logic [63:0]              link_addr_i,
   input  logic [vaddr_width_p-1:0] target_pc_i,

   // rd write
   output logic                     rd_w_v_o,
   output logic [63:0]              rd_data_o,

   // Fetch redirect
   output logic                     redirect_v_o,
   output logic [vaddr_width_p-1:0] redirect_pc_o
);

   localparam int reg_data_width_lp = rv64_pkg::rv64_reg_data_width_gp;

   logic                         branch_taken;
   logic                         rd_w_v_n;
   logic                         redirect_v_n;
   logic [reg_data_width_lp-1:0] rd_data_n;

   // Compare result lands in bit 0
   assign branch_taken = alu_result_i[0];

   // Write and redirect decision by class
   always_comb
   begin
      rd_w_v_n     = 1'b0;
      redirect_v_n = 1'b0;
      rd_data_n    = alu_result_i;
      case (class_i)
         int_pkg::e_class_alu :
         begin
            rd_w_v_n = valid_i;
         end
         // No rd write on branches
         int_pkg::e_class_branch :
         begin
            redirect_v_n = valid_i & branch_taken;
         end
         // Jumps link and always redirect
         int_pkg::e_class_jal, int_pkg::e_class_jalr :
         begin
            rd_w_v_n     = valid_i;
            redirect_v_n = valid_i;
            rd_data_n    = link_addr_i;
         end
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         rd_w_v_o      <= 1'b0;
         redirect_v_o  <= 1'b0;
         rd_data_o     <= '0;
         redirect_pc_o <= '0;
      end
      else
      begin
         rd_w_v_o     <= rd_w_v_n;
         redirect_v_o <= redirect_v_n;
         // Payload only moves with its enable
         if (rd_w_v_n)
         begin
            rd_data_o <= rd_data_n;
         end
         if (redirect_v_n)
         begin
            redirect_pc_o <= target_pc_i;
         end
      end
   end

endmodule : int_commit

// File: hdl/int_target_gen.sv
// Branch and jump target generator with no misaligned-target check and targets truncated to vaddr_width_p
module int_target_gen
#(
   parameter int vaddr_width_p = 39
)
(
   input  logic [vaddr_width_p-1:0] pc_i,
   input  logic [63:0]              src1_i,
   // Immediate arrives sign extended to 64 bits
   input  logic [63:0]              imm_i,
   input  int_pkg::int_class_e      class_i,

   output logic [vaddr_width_p-1:0] target_pc_o,
   output logic [63:0]              link_addr_o
);

   localparam int reg_data_width_lp = rv64_pkg::rv64_reg_data_width_gp;

   logic                         is_jalr;
   logic [reg_data_width_lp-1:0] base_addr;
   logic [reg_data_width_lp-1:0] sum_addr;
   logic [vaddr_width_p-1:0]     target_raw;
   logic [vaddr_width_p-1:0]     link_pc;

   assign is_jalr = (class_i == int_pkg::e_class_jalr);

   // Base address by class
   always_comb
   begin
      case (class_i)
         // Register indirect
         int_pkg::e_class_jalr : base_addr = src1_i;
         // branch, jal, and don't-care for alu
         default               : base_addr = reg_data_width_lp'(pc_i);
      endcase
   end

   // Full width add, then cut down to the virtual address
   assign sum_addr   = base_addr + imm_i;
   assign target_raw = sum_addr[vaddr_width_p-1:0];

   // jalr drops the LSB of the target
   assign target_pc_o = is_jalr ? {target_raw[vaddr_width_p-1:1], 1'b0} : target_raw;

   // Return address, wraps within vaddr then zero extends
   assign link_pc     = pc_i + vaddr_width_p'(rv64_pkg::rv64_instr_bytes_gp);
   assign link_addr_o = reg_data_width_lp'(link_pc);

endmodule : int_target_gen

// File: hdl/int_alu.sv
// Combinational RV64I ALU without multiply or divide and with word results sign-extended from bit 31
module int_alu
(
   // Operands, src2 already holds the immediate for I-type ops
   input  logic [63:0]             src1_i,
   input  logic [63:0]             src2_i,

   // Operation and word-width flag
   input  int_pkg::int_fu_op_e     op_i,
   input  logic                    opw_v_i,

   output logic [63:0]             result_o
);

   localparam int reg_data_width_lp = rv64_pkg::rv64_reg_data_width_gp;
   localparam int word_width_lp     = rv64_pkg::rv64_word_width_gp;
   localparam int shamt_width_lp    = rv64_pkg::rv64_shamt_width_gp;
   localparam int shamtw_width_lp   = rv64_pkg::rv64_shamtw_width_gp;

   // Signed views of the operands
   logic signed [reg_data_width_lp-1:0] src1_sgn;
   logic signed [reg_data_width_lp-1:0] src2_sgn;
   logic signed [word_width_lp-1:0]     src1_w_sgn;
   logic signed [word_width_lp-1:0]     src2_w_sgn;

   // Full and word results
   logic signed [reg_data_width_lp-1:0] result_sgn;
   logic signed [word_width_lp-1:0]     resultw_sgn;

   // Shift amounts from the low bits of src2
   logic        [shamt_width_lp-1:0]    shamt;
   logic        [shamtw_width_lp-1:0]   shamtw;

   assign src1_sgn   = $signed(src1_i);
   assign src2_sgn   = $signed(src2_i);
   assign src1_w_sgn = $signed(src1_i[word_width_lp-1:0]);
   assign src2_w_sgn = $signed(src2_i[word_width_lp-1:0]);

   assign shamt  = src2_i[shamt_width_lp-1:0];
   assign shamtw = src2_i[shamtw_width_lp-1:0];

   // Word ops, only add/sub and shifts exist in RV64I
   always_comb
   begin
      case (op_i)
         int_pkg::e_int_op_add : resultw_sgn = src1_w_sgn + src2_w_sgn;
         int_pkg::e_int_op_sub : resultw_sgn = src1_w_sgn - src2_w_sgn;
         int_pkg::e_int_op_sll : resultw_sgn = src1_w_sgn << shamtw;
         // Logical shift fills with zeros even on a signed operand
         int_pkg::e_int_op_srl : resultw_sgn = src1_w_sgn >> shamtw;
         int_pkg::e_int_op_sra : resultw_sgn = src1_w_sgn >>> shamtw;
         default               : resultw_sgn = '0;
      endcase
   end

   // Full width ops
   always_comb
   begin
      case (op_i)
         int_pkg::e_int_op_add       : result_sgn = src1_sgn + src2_sgn;
         int_pkg::e_int_op_sub       : result_sgn = src1_sgn - src2_sgn;
         int_pkg::e_int_op_xor       : result_sgn = src1_sgn ^ src2_sgn;
         int_pkg::e_int_op_or        : result_sgn = src1_sgn | src2_sgn;
         int_pkg::e_int_op_and       : result_sgn = src1_sgn & src2_sgn;
         int_pkg::e_int_op_sll       : result_sgn = src1_sgn << shamt;
         int_pkg::e_int_op_srl       : result_sgn = src1_sgn >> shamt;
         int_pkg::e_int_op_sra       : result_sgn = src1_sgn >>> shamt;
         int_pkg::e_int_op_pass_src2 : result_sgn = src2_sgn;
         // Single bit results, zero extended
         int_pkg::e_int_op_slt  : result_sgn = reg_data_width_lp'(src1_sgn < src2_sgn);
         int_pkg::e_int_op_sge  : result_sgn = reg_data_width_lp'(src1_sgn >= src2_sgn);
         int_pkg::e_int_op_eq   : result_sgn = reg_data_width_lp'(src1_i == src2_i);
         int_pkg::e_int_op_ne   : result_sgn = reg_data_width_lp'(src1_i != src2_i);
         int_pkg::e_int_op_sltu : result_sgn = reg_data_width_lp'(src1_i < src2_i);
         int_pkg::e_int_op_sgeu : result_sgn = reg_data_width_lp'(src1_i >= src2_i);
         default                : result_sgn = '0;
      endcase
   end

   // Word result sign extended from bit 31
   // Unused word opcodes give zero
   assign result_o = opw_v_i
                   ? {{(reg_data_width_lp-word_width_lp){resultw_sgn[word_width_lp-1]}},
                      resultw_sgn}
                   : result_sgn;

endmodule : int_alu

// File: hdl/int_pkg.sv
// Integer unit encodings for the execute stage, with no multiply, divide or memory ops
package int_pkg;

   // ALU operation select
   // Compare ops are shared between slt-type instructions and branches
   typedef enum logic [3:0]
   {
      e_int_op_add       = 4'b0000,
      e_int_op_sub       = 4'b0001,
      e_int_op_xor       = 4'b0010,
      e_int_op_or        = 4'b0011,
      e_int_op_and       = 4'b0100,
      e_int_op_sll       = 4'b0101,
      e_int_op_srl       = 4'b0110,
      e_int_op_sra       = 4'b0111,
      // Forwards src2 (lui style)
      e_int_op_pass_src2 = 4'b1000,
      // Signed compares
      e_int_op_slt       = 4'b1001,
      e_int_op_sge       = 4'b1010,
      // Equality
      e_int_op_eq        = 4'b1011,
      e_int_op_ne        = 4'b1100,
      // Unsigned compares
      e_int_op_sltu      = 4'b1101,
      e_int_op_sgeu      = 4'b1110
   } int_fu_op_e;

   // Instruction class
   // Decides rd write and redirect in the commit stage
   typedef enum logic [1:0]
   {
      // Register or immediate arithmetic
      e_class_alu    = 2'b00,
      // Conditional branch, outcome from ALU bit 0
      e_class_branch = 2'b01,
      // PC relative jump
      e_class_jal    = 2'b10,
      // Register indirect jump
      e_class_jalr   = 2'b11
   } int_class_e;

endpackage : int_pkg

// File: hdl/rv64_pkg.sv
// RV64I widths and constants taken from the base ISA only, with no compressed instructions
package rv64_pkg;

   // Architectural integer register width
   localparam int rv64_reg_data_width_gp = 64;

   // Word width for the *W instructions
   localparam int rv64_word_width_gp = 32;

   // Shift amount for 64-bit shifts
   // Low 6 bits of src2
   localparam int rv64_shamt_width_gp = 6;

   // Shift amount for word shifts
   // Low 5 bits of src2
   localparam int rv64_shamtw_width_gp = 5;

   // Size of one uncompressed instruction
   // Used for the link address of jal and jalr
   localparam int rv64_instr_bytes_gp = 4;

endpackage : rv64_pkg
